//--- src/rxReqPkg.sv
package rxReqPkg;

    // Beat geometry, fixed at four dwords
    localparam int beatDwords = 4;
    localparam int dwordW     = 32;

    typedef logic [beatDwords*dwordW-1:0] beatT;
    typedef logic [4*dwordW-1:0]          hdrT;     // Dword 0 in the low bits
    typedef logic [1:0]                   dwOffsetT;
    typedef logic [beatDwords-1:0]        dwMaskT;
    typedef logic [63:0]                  addrT;
    typedef logic [9:0]                   reqLenT;  // Length in dwords
    typedef logic [7:0]                   tagT;
    typedef logic [15:0]                  reqIdT;
    typedef logic [3:0]                   beT;
    typedef logic [2:0]                   tcT;
    typedef logic [1:0]                   attrT;

    typedef enum logic [2:0] {
        memRead,
        memWrite,
        ioRead,
        ioWrite,
        notRequest
    } reqKindT;

    typedef enum logic {
        idle,
        inPacket
    } pktStateT;

    localparam dwMaskT allDwords = '1;

    // Dword 0 fields
    localparam int lenLsb     = 0;
    localparam int attrLsb    = 12;
    localparam int epBit      = 14;     // Poisoned
    localparam int tcLsb      = 20;
    localparam int typeLsb    = 24;
    localparam int typeW      = 5;
    localparam int fourDwBit  = 29;     // Fmt bit 0, header is 4 dwords
    localparam int payloadBit = 30;     // Fmt bit 1, packet has data

    // Dword 1 fields
    localparam int firstBeLsb = 32;
    localparam int lastBeLsb  = 36;
    localparam int tagLsb     = 40;
    localparam int reqIdLsb   = 48;

    // Address dwords
    localparam int dw2Lsb = 64;
    localparam int dw3Lsb = 96;

    // Type codes that count as requests
    localparam logic [typeW-1:0] typeMem = 5'b00000;
    localparam logic [typeW-1:0] typeIo  = 5'b00010;

endpackage

//--- src/rxReqIfs.sv
// Registered beat stream out of the input register chain
interface rxBeatIf
    import rxReqPkg::*;
();
    beatT     data;
    logic     valid;
    logic     sop;
    logic     eop;
    dwOffsetT endOffset;

    modport source (output data, valid, sop, eop, endOffset);
    modport sink   (input  data, valid, sop, eop, endOffset);
endinterface

// Beat stream one cycle on, with captured header and start info
interface rxHdrIf
    import rxReqPkg::*;
();
    beatT     data;
    logic     valid;
    logic     sop;
    logic     eop;
    dwOffsetT endOffset;
    hdrT      hdr;
    logic     startFlag;    // First beat that carries payload or ends the header
    dwOffsetT startOffset;

    modport source (
        output data, valid, sop, eop, endOffset,
        output hdr, startFlag, startOffset
    );
    modport sink (
        input data, valid, sop, eop, endOffset,
        input hdr, startFlag, startOffset
    );
endinterface

//--- src/rxInputStage.sv
module rxInputStage
    import rxReqPkg::*;
#(
    parameter int inputStages = 1
) (
    input  logic     CLK,
    input  logic     rst,
    input  beatT     rxData,
    input  logic     rxValid,
    input  logic     rxSop,
    input  logic     rxEop,
    input  dwOffsetT rxEndOffset,
    rxBeatIf.source  beat
);

    beatT                   dataSr   [inputStages];
    dwOffsetT               endOffSr [inputStages];
    logic [inputStages-1:0] validSr;
    logic [inputStages-1:0] sopSr;
    logic [inputStages-1:0] eopSr;

    // Strobes shift through with reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            validSr <= '0;
            sopSr   <= '0;
            eopSr   <= '0;
        end else begin
            validSr[0] <= rxValid;
            sopSr[0]   <= rxSop;
            eopSr[0]   <= rxEop;
            for (int i = 1; i < inputStages; i++) begin
                validSr[i] <= validSr[i-1];
                sopSr[i]   <= sopSr[i-1];
                eopSr[i]   <= eopSr[i-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        dataSr[0]   <= rxData;
        endOffSr[0] <= rxEndOffset;
        for (int i = 1; i < inputStages; i++) begin
            dataSr[i]   <= dataSr[i-1];
            endOffSr[i] <= endOffSr[i-1];
        end
    end

    assign beat.data      = dataSr[inputStages-1];
    assign beat.valid     = validSr[inputStages-1];
    assign beat.sop       = sopSr[inputStages-1];
    assign beat.eop       = eopSr[inputStages-1];
    assign beat.endOffset = endOffSr[inputStages-1];

endmodule

//--- src/rxHeaderCapture.sv
module rxHeaderCapture
    import rxReqPkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    rxBeatIf.sink    beat,
    rxHdrIf.source   hdrStage
);

    beatT     dataQ;
    dwOffsetT endOffQ;
    hdrT      hdrQ;
    logic     validQ;
    logic     sopQ;
    logic     eopQ;
    logic     delayedSop;   // Last valid beat was an SOP
    logic     dataStartQ;
    logic     sopIn;
    logic     dataStartIn;
    logic     hdr3DwStart;
    logic     hdr4DwNoDataStart;

    assign sopIn = beat.valid & beat.sop;

    // First data beat behind a 4DW header, header register already loaded
    assign dataStartIn = beat.valid & delayedSop & hdrQ[fourDwBit] & hdrQ[payloadBit];

    always_ff @(posedge CLK) begin
        if (rst) begin
            validQ     <= 1'b0;
            sopQ       <= 1'b0;
            eopQ       <= 1'b0;
            delayedSop <= 1'b0;
            dataStartQ <= 1'b0;
        end else begin
            validQ     <= beat.valid;
            sopQ       <= sopIn;
            eopQ       <= beat.valid & beat.eop;
            dataStartQ <= dataStartIn;
            if (beat.valid) begin
                delayedSop <= beat.sop;   // Gaps keep the flag
            end
        end
    end

    always_ff @(posedge CLK) begin
        dataQ   <= beat.data;
        endOffQ <= beat.endOffset;
        if (sopIn) begin
            hdrQ <= beat.data;
        end
    end

    // 3DW header leaves dword 3 of the SOP beat for data
    assign hdr3DwStart = sopQ & ~hdrQ[fourDwBit];
    assign hdr4DwNoDataStart = sopQ & hdrQ[fourDwBit] & ~hdrQ[payloadBit];

    assign hdrStage.data        = dataQ;
    assign hdrStage.valid       = validQ;
    assign hdrStage.sop         = sopQ;
    assign hdrStage.eop         = eopQ;
    assign hdrStage.endOffset   = endOffQ;
    assign hdrStage.hdr         = hdrQ;
    assign hdrStage.startFlag   = hdr3DwStart | hdr4DwNoDataStart | dataStartQ;
    assign hdrStage.startOffset = hdr3DwStart ? dwOffsetT'(3) : dwOffsetT'(0);

endmodule

//--- src/rxReqDecode.sv
module rxReqDecode
    import rxReqPkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    rxHdrIf.sink     hdrStage,
    output beatT     decData,
    output logic     decValid,
    output logic     decStartFlag,
    output dwOffsetT decStartOffset,
    output logic     decEndFlag,
    output dwOffsetT decEndOffset,
    output dwMaskT   decStartMask,
    output dwMaskT   decEndMask,
    output logic     decHasPayload,
    output beT       decFirstBe,
    output beT       decLastBe,
    output tcT       decTc,
    output attrT     decAttr,
    output tagT      decTag,
    output reqKindT  decKind,
    output addrT     decAddr,
    output reqIdT    decRequesterId,
    output reqLenT   decLength,
    output logic     decEp
);

    pktStateT state;
    pktStateT nextState;
    reqKindT  kind;
    logic     isReq;
    logic     endFlag;
    logic     reqStart;
    logic     beatMarked;
    dwMaskT   startMask;
    dwMaskT   endMask;
    addrT     addr;

    // Format and type to request kind
    always_comb begin
        case (hdrStage.hdr[typeLsb +: typeW])
            typeMem: kind = hdrStage.hdr[payloadBit] ? memWrite : memRead;
            typeIo:  kind = hdrStage.hdr[payloadBit] ? ioWrite : ioRead;
            default: kind = notRequest;     // Completions, messages
        endcase
    end

    assign isReq    = (kind != notRequest);
    assign endFlag  = hdrStage.valid & hdrStage.eop;
    assign reqStart = hdrStage.startFlag & isReq;

    // Single cycle packet or any valid beat of an open one
    assign beatMarked = hdrStage.valid & (reqStart | (state == inPacket));

    always_comb begin
        nextState = state;
        if (reqStart && !endFlag) begin
            nextState = inPacket;
        end else if (endFlag || hdrStage.sop) begin
            nextState = idle;   // Stray SOP closes a broken packet
        end
    end

    assign startMask = hdrStage.startFlag ? dwMaskT'(allDwords << hdrStage.startOffset)
                                          : allDwords;
    assign endMask = endFlag ? dwMaskT'(allDwords >> (2'd3 - hdrStage.endOffset))
                             : allDwords;

    // 4DW header carries the upper half first
    assign addr = hdrStage.hdr[fourDwBit] ?
                  {hdrStage.hdr[dw2Lsb +: dwordW], hdrStage.hdr[dw3Lsb +: dwordW]} :
                  {{dwordW{1'b0}}, hdrStage.hdr[dw2Lsb +: dwordW]};

    always_ff @(posedge CLK) begin
        if (rst) begin
            state        <= idle;
            decValid     <= 1'b0;
            decStartFlag <= 1'b0;
            decEndFlag   <= 1'b0;
        end else begin
            state        <= nextState;
            decValid     <= beatMarked;
            decStartFlag <= reqStart;
            decEndFlag   <= endFlag & beatMarked;
        end
    end

    always_ff @(posedge CLK) begin
        decData        <= hdrStage.data;
        decStartOffset <= hdrStage.startOffset;
        decEndOffset   <= hdrStage.endOffset;
        decStartMask   <= startMask;
        decEndMask     <= endMask;
        decHasPayload  <= hdrStage.hdr[payloadBit];
        decFirstBe     <= hdrStage.hdr[firstBeLsb +: $bits(beT)];
        decLastBe      <= hdrStage.hdr[lastBeLsb +: $bits(beT)];
        decTc          <= hdrStage.hdr[tcLsb +: $bits(tcT)];
        decAttr        <= hdrStage.hdr[attrLsb +: $bits(attrT)];
        decTag         <= hdrStage.hdr[tagLsb +: $bits(tagT)];
        decKind        <= kind;
        decAddr        <= addr;
        decRequesterId <= hdrStage.hdr[reqIdLsb +: $bits(reqIdT)];
        decLength      <= hdrStage.hdr[lenLsb +: $bits(reqLenT)];
        decEp          <= hdrStage.hdr[epBit];
    end

endmodule

//--- src/rxReqOutput.sv
module rxReqOutput
    import rxReqPkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    input  beatT     decData,
    input  logic     decValid,
    input  logic     decStartFlag,
    input  dwOffsetT decStartOffset,
    input  logic     decEndFlag,
    input  dwOffsetT decEndOffset,
    input  dwMaskT   decStartMask,
    input  dwMaskT   decEndMask,
    input  logic     decHasPayload,
    input  beT       decFirstBe,
    input  beT       decLastBe,
    input  tcT       decTc,
    input  attrT     decAttr,
    input  tagT      decTag,
    input  reqKindT  decKind,
    input  addrT     decAddr,
    input  reqIdT    decRequesterId,
    input  reqLenT   decLength,
    input  logic     decEp,
    output beatT     reqData,
    output logic     reqValid,
    output dwMaskT   reqWordEnable,
    output logic     reqStartFlag,
    output dwOffsetT reqStartOffset,
    output logic     reqEndFlag,
    output dwOffsetT reqEndOffset,
    output beT       reqFirstBe,
    output beT       reqLastBe,
    output tcT       reqTc,
    output attrT     reqAttr,
    output tagT      reqTag,
    output reqKindT  reqKind,
    output addrT     reqAddr,
    output reqIdT    reqRequesterId,
    output reqLenT   reqLength,
    output logic     reqEp
);

    dwMaskT wordEnable;

    // Reads carry no data dwords
    assign wordEnable = (decValid && decHasPayload) ? (decStartMask & decEndMask) : '0;

    always_ff @(posedge CLK) begin
        if (rst) begin
            reqValid      <= 1'b0;
            reqStartFlag  <= 1'b0;
            reqEndFlag    <= 1'b0;
            reqWordEnable <= '0;
        end else begin
            reqValid      <= decValid;
            reqStartFlag  <= decStartFlag;
            reqEndFlag    <= decEndFlag;
            reqWordEnable <= wordEnable;
        end
    end

    always_ff @(posedge CLK) begin
        reqData        <= decData;
        reqStartOffset <= decStartOffset;
        reqEndOffset   <= decEndOffset;
        reqFirstBe     <= decFirstBe;
        reqLastBe      <= decLastBe;
        reqTc          <= decTc;
        reqAttr        <= decAttr;
        reqTag         <= decTag;
        reqKind        <= decKind;
        reqAddr        <= decAddr;
        reqRequesterId <= decRequesterId;
        reqLength      <= decLength;
        reqEp          <= decEp;
    end

endmodule

//--- src/rxReqEngine.sv
module rxReqEngine
    import rxReqPkg::*;
#(
    parameter int inputStages = 1   // 1 to 3
) (
    input  logic     CLK,
    input  logic     rst,
    input  beatT     rxData,
    input  logic     rxValid,
    input  logic     rxSop,
    input  logic     rxEop,
    input  dwOffsetT rxEndOffset,
    output beatT     reqData,
    output logic     reqValid,
    output dwMaskT   reqWordEnable,
    output logic     reqStartFlag,
    output dwOffsetT reqStartOffset,
    output logic     reqEndFlag,
    output dwOffsetT reqEndOffset,
    output beT       reqFirstBe,
    output beT       reqLastBe,
    output tcT       reqTc,
    output attrT     reqAttr,
    output tagT      reqTag,
    output reqKindT  reqKind,
    output addrT     reqAddr,
    output reqIdT    reqRequesterId,
    output reqLenT   reqLength,
    output logic     reqEp
);

    rxBeatIf beatBus ();
    rxHdrIf  hdrBus ();

    // Decode to output stage, names match the port names
    beatT     decData;
    logic     decValid;
    logic     decStartFlag;
    dwOffsetT decStartOffset;
    logic     decEndFlag;
    dwOffsetT decEndOffset;
    dwMaskT   decStartMask;
    dwMaskT   decEndMask;
    logic     decHasPayload;
    beT       decFirstBe;
    beT       decLastBe;
    tcT       decTc;
    attrT     decAttr;
    tagT      decTag;
    reqKindT  decKind;
    addrT     decAddr;
    reqIdT    decRequesterId;
    reqLenT   decLength;
    logic     decEp;

    rxInputStage #(
        .inputStages (inputStages)
    ) u_rxInputStage (
        .beat (beatBus),
        .*
    );

    rxHeaderCapture u_rxHeaderCapture (
        .CLK      (CLK),
        .rst      (rst),
        .beat     (beatBus),
        .hdrStage (hdrBus)
    );

    rxReqDecode u_rxReqDecode (
        .hdrStage (hdrBus),
        .*
    );

    rxReqOutput u_rxReqOutput (.*);

endmodule

//--- bench/rxReqTests.svh
`ifndef RX_REQ_TESTS_SVH
`define RX_REQ_TESTS_SVH

// Header dwords packed from the field layout, dword 0 lowest
function automatic hdrT makeHeader(pktT p);
    hdrT h;
    h = '0;
    h[9:0]   = p.len;
    h[13:12] = p.attr;
    h[14]    = p.ep;
    h[22:20] = p.tc;
    h[28:24] = p.typeCode;
    h[29]    = p.fourDw;
    h[30]    = p.hasData;
    h[63:32] = {p.reqId, p.tag, p.lastBe, p.firstBe};
    if (p.fourDw) begin
        h[95:64]  = p.addr[63:32];
        h[127:96] = p.addr[31:0];
    end else begin
        h[95:64] = p.addr[31:0];
    end
    return h;
endfunction

function automatic pktT makePkt(reqKindT kind, logic fourDw, int len);
    pktT         p;
    logic [31:0] r;
    p          = '0;
    r          = nextRand();
    p.kind     = kind;
    p.fourDw   = fourDw;
    p.hasData  = (kind == memWrite) || (kind == ioWrite);
    p.typeCode = (kind == ioRead || kind == ioWrite) ? 5'b00010 : 5'b00000;
    p.len      = reqLenT'(len);
    p.attr     = r[1:0];
    p.ep       = r[2];
    p.tc       = r[5:3];
    p.firstBe  = r[9:6];
    p.lastBe   = r[13:10];
    p.tag      = r[21:14];
    r          = nextRand();
    p.reqId    = r[15:0];
    p.addr     = {nextRand(), nextRand()};
    p.addr[1:0] = 2'b00;        // Dword aligned
    if (!fourDw) begin
        p.addr[63:32] = '0;
    end
    p.nData = p.hasData ? len : 0;
    return p;
endfunction

task automatic driveBeat(beatT d, logic v, logic s, logic e, dwOffsetT eo, expT x);
    @(posedge CLK);
    #2;
    rxData      = d;
    rxValid     = v;
    rxSop       = s;
    rxEop       = e;
    rxEndOffset = eo;
    x.due       = cyc + reqLatency;
    expQ.push_back(x);
    beatCount++;
endtask

task automatic idleBeats(int n);
    expT x;
    for (int i = 0; i < n; i++) begin
        x = '0;
        driveBeat({nextRand(), nextRand(), nextRand(), nextRand()}, 1'b0, 1'b0, 1'b0, '0, x);
    end
endtask

// Gap modes: 0 none, 1 after every beat, 2 random
task automatic sendPacket(pktT p, int gapMode);
    logic [31:0] dw [$];
    hdrT         h;
    beatT        d;
    expT         x;
    int          hdrDw;
    int          total;
    int          nBeats;
    int          startBeat;
    int          idx;
    logic        isReq;
    h     = makeHeader(p);
    hdrDw = p.fourDw ? 4 : 3;
    for (int i = 0; i < hdrDw; i++) dw.push_back(h[i*32 +: 32]);
    for (int i = 0; i < p.nData; i++) dw.push_back(nextRand());
    total     = dw.size();
    nBeats    = (total + 3) / 4;
    startBeat = (p.fourDw && p.hasData) ? 1 : 0;   // 4DW header fills the SOP beat
    isReq     = (p.kind != notRequest);
    for (int b = 0; b < nBeats; b++) begin
        x       = '0;
        x.p     = p;
        x.valid = isReq && (b >= startBeat);
        x.sf    = isReq && (b == startBeat);
        x.so    = p.fourDw ? 2'd0 : 2'd3;
        x.ef    = isReq && (b == nBeats - 1);
        x.eo    = dwOffsetT'((total - 1) % 4);
        for (int k = 0; k < 4; k++) begin
            idx = b * 4 + k;
            d[k*32 +: 32] = (idx < total) ? dw[idx] : nextRand();
            x.we[k] = x.valid && p.hasData && (idx >= hdrDw) && (idx < total);
        end
        x.data      = d;
        x.checkData = 1'b1;
        driveBeat(d, 1'b1, b == 0, b == nBeats - 1, x.eo, x);
        if (b < nBeats - 1 && (gapMode == 1 || (gapMode == 2 && nextRand() % 3 == 0))) begin
            idleBeats(1);
        end
    end
endtask

task automatic compareBeat(expT x);
    if (x.checkData) check("data", reqData, x.data);
    check("valid", reqValid, x.valid);
    check("start flag", reqStartFlag, x.sf);
    check("end flag", reqEndFlag, x.ef);
    check("word enable", reqWordEnable, x.we);
    if (x.sf) check("start offset", reqStartOffset, x.so);
    if (x.ef) check("end offset", reqEndOffset, x.eo);
    if (x.valid) begin
        check("first BE", reqFirstBe, x.p.firstBe);
        check("last BE", reqLastBe, x.p.lastBe);
        check("traffic class", reqTc, x.p.tc);
        check("attributes", reqAttr, x.p.attr);
        check("tag", reqTag, x.p.tag);
        check("requester ID", reqRequesterId, x.p.reqId);
        check("length", reqLength, x.p.len);
        check("poisoned", reqEp, x.p.ep);
        check("kind", reqKind, x.p.kind);
        check("address", reqAddr, x.p.fourDw ? x.p.addr : {32'h0, x.p.addr[31:0]});
    end
endtask

task automatic finishTest(string name, int errBefore);
    idleBeats(1);
    while (expQ.size() != 0) @(posedge CLK);    // Let the pipeline drain
    testCount++;
    if (errors == errBefore) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - errBefore);
    end
endtask

task automatic testIdleAfterReset();
    int e0;
    e0 = errors;
    idleBeats(8);
    finishTest("idle after reset", e0);
endtask

task automatic testSingleWrite();
    int e0;
    e0 = errors;
    sendPacket(makePkt(memWrite, 1'b0, 1), 0);
    finishTest("single beat 3DW write", e0);
endtask

task automatic testMultiBeatWrite();
    int e0;
    e0 = errors;
    sendPacket(makePkt(memWrite, 1'b1, 7), 1);
    finishTest("multi beat 4DW write with gaps", e0);
endtask

task automatic testReadsAndIo();
    int e0;
    e0 = errors;
    sendPacket(makePkt(memRead, 1'b0, 4), 0);
    sendPacket(makePkt(memRead, 1'b1, 16), 0);
    sendPacket(makePkt(ioWrite, 1'b0, 1), 0);
    finishTest("reads and IO write", e0);
endtask

task automatic testDroppedPackets();
    pktT p;
    int  e0;
    e0 = errors;
    p          = makePkt(notRequest, 1'b0, 2);
    p.typeCode = 5'b01010;      // Completion with data
    p.hasData  = 1'b1;
    p.nData    = 2;
    sendPacket(p, 0);
    p          = makePkt(notRequest, 1'b1, 3);
    p.typeCode = 5'b10000;      // Message routed to root
    p.hasData  = 1'b1;
    p.nData    = 3;
    sendPacket(p, 1);
    finishTest("completion and message dropped", e0);
endtask

task automatic testRandomBurst();
    reqKindT kind;
    logic    fourDw;
    int      e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
        kind   = reqKindT'(nextRand() % 4);
        fourDw = (kind == memRead || kind == memWrite) ? nextRand() % 2 == 1 : 1'b0;
        sendPacket(makePkt(kind, fourDw, 1 + int'(nextRand() % 12)), 2);
    end
    finishTest("random back to back requests", e0);
endtask

`endif

//--- bench/rxReqTb.sv
module rxReqTb
    import rxReqPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int inputStages = 1;
    localparam int reqLatency  = inputStages + 3;

    // One packet as the bench sees it, fields before packing
    typedef struct packed {
        logic       fourDw;
        logic       hasData;
        logic [4:0] typeCode;
        reqKindT    kind;
        reqLenT     len;
        attrT       attr;
        logic       ep;
        tcT         tc;
        beT         firstBe;
        beT         lastBe;
        tagT        tag;
        reqIdT      reqId;
        addrT       addr;
        int         nData;      // Payload dwords actually sent
    } pktT;

    // Expected output beat, due at a given cycle
    typedef struct packed {
        int       due;
        logic     checkData;
        beatT     data;
        logic     valid;
        logic     sf;
        dwOffsetT so;
        logic     ef;
        dwOffsetT eo;
        dwMaskT   we;
        pktT      p;
    } expT;

    logic     CLK = 1'b0;
    logic     rst;
    beatT     rxData;
    logic     rxValid;
    logic     rxSop;
    logic     rxEop;
    dwOffsetT rxEndOffset;
    beatT     reqData;
    logic     reqValid;
    dwMaskT   reqWordEnable;
    logic     reqStartFlag;
    dwOffsetT reqStartOffset;
    logic     reqEndFlag;
    dwOffsetT reqEndOffset;
    beT       reqFirstBe;
    beT       reqLastBe;
    tcT       reqTc;
    attrT     reqAttr;
    tagT      reqTag;
    reqKindT  reqKind;
    addrT     reqAddr;
    reqIdT    reqRequesterId;
    reqLenT   reqLength;
    logic     reqEp;

    int          cyc = 0;
    int          beatCount = 0;
    int          checks = 0;
    int          errors = 0;
    int          testCount = 0;
    int unsigned lcgState = 96;
    expT         expQ [$];

    always #20 CLK = ~CLK;

    always @(posedge CLK) cyc <= cyc + 1;

    rxReqEngine #(
        .inputStages (inputStages)
    ) u_rxReqEngine (.*);

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic check(string what, logic [127:0] got, logic [127:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    `include "rxReqTests.svh"

    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge CLK) begin
        if (expQ.size() != 0 && expQ[0].due == cyc) begin
            compareBeat(expQ.pop_front());
        end
    end

    // Limit grows with every beat driven
    initial begin
        while (cyc <= 2 * beatCount + 200) @(posedge CLK);
        $display("Timeout: run passed %0d cycles with output beats still pending", cyc);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        rxData      = '0;
        rxValid     = 1'b0;
        rxSop       = 1'b0;
        rxEop       = 1'b0;
        rxEndOffset = '0;
        repeat (5) @(posedge CLK);
        #2 rst = 1'b0;
        testIdleAfterReset();
        testSingleWrite();
        testMultiBeatWrite();
        testReadsAndIo();
        testDroppedPackets();
        testRandomBurst();
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+bench
src/rxReqPkg.sv
src/rxReqIfs.sv
src/rxInputStage.sv
src/rxHeaderCapture.sv
src/rxReqDecode.sv
src/rxReqOutput.sv
src/rxReqEngine.sv
bench/rxReqTb.sv
